// ==== rtl/sigmoidPkg.sv ====
package sigmoidPkg;

    // Fixed-point format of the layer values
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // Segment index at steps of one tenth
    localparam int SEG_W = 8;
    localparam int SEG_MIN = -60;
    localparam int SEG_MAX = 60;
    localparam int SEG_COUNT = SEG_MAX - SEG_MIN + 1;

    typedef logic signed [DATA_W-1:0] preAct_t;
    typedef logic [DATA_W-1:0] act_t;
    typedef logic signed [SEG_W-1:0] segIdx_t;

    // Which side of the clamp the segment landed on
    typedef enum logic [1:0] {
        SEG_LOW,
        SEG_MID,
        SEG_HIGH
    } segKind_e;

    // Stage-1 lane result
    typedef struct packed {
        segKind_e kind;
        segIdx_t  idx;
    } lookup_s;

    // Collector occupancy
    typedef enum logic [1:0] {
        BUF_EMPTY,
        BUF_ONE,
        BUF_TWO
    } bufState_e;

    // round(256 * sigmoid(k / 10)), indexed by k + 60
    // End entries pinned to 0 and 256
    localparam act_t SIGMOID_TABLE [0:SEG_COUNT-1] = '{
        // -60 to -51
        16'd0,   16'd1,   16'd1,   16'd1,   16'd1,
        16'd1,   16'd1,   16'd1,   16'd1,   16'd2,
        // -50 to -41
        16'd2,   16'd2,   16'd2,   16'd2,   16'd3,
        16'd3,   16'd3,   16'd3,   16'd4,   16'd4,
        // -40 to -31
        16'd5,   16'd5,   16'd6,   16'd6,   16'd7,
        16'd8,   16'd8,   16'd9,   16'd10,  16'd11,
        // -30 to -21
        16'd12,  16'd13,  16'd15,  16'd16,  16'd18,
        16'd19,  16'd21,  16'd23,  16'd26,  16'd28,
        // -20 to -11
        16'd31,  16'd33,  16'd36,  16'd40,  16'd43,
        16'd47,  16'd51,  16'd55,  16'd59,  16'd64,
        // -10 to -1
        16'd69,  16'd74,  16'd79,  16'd85,  16'd91,
        16'd97,  16'd103, 16'd109, 16'd115, 16'd122,
        // 0 to 9
        16'd128, 16'd134, 16'd141, 16'd147, 16'd153,
        16'd159, 16'd165, 16'd171, 16'd177, 16'd182,
        // 10 to 19
        16'd187, 16'd192, 16'd197, 16'd201, 16'd205,
        16'd209, 16'd213, 16'd216, 16'd220, 16'd223,
        // 20 to 29
        16'd225, 16'd228, 16'd230, 16'd233, 16'd235,
        16'd237, 16'd238, 16'd240, 16'd241, 16'd243,
        // 30 to 39
        16'd244, 16'd245, 16'd246, 16'd247, 16'd248,
        16'd248, 16'd249, 16'd250, 16'd250, 16'd251,
        // 40 to 49
        16'd251, 16'd252, 16'd252, 16'd253, 16'd253,
        16'd253, 16'd253, 16'd254, 16'd254, 16'd254,
        // 50 to 60
        16'd254, 16'd254, 16'd255, 16'd255, 16'd255,
        16'd255, 16'd255, 16'd255, 16'd255, 16'd255,
        16'd256
    };

endpackage

// ==== rtl/neuronDispatch.sv ====
`timescale 1ns/1ps

module neuronDispatch #(
    parameter int NUM_LANES = 10
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 inValid,
    output logic                                 inReady,
    input  sigmoidPkg::preAct_t [NUM_LANES-1:0] inData,
    input  logic                                 collectReady,
    output sigmoidPkg::preAct_t [NUM_LANES-1:0] laneIn,
    output logic                                 advance,
    output logic                                 resValid
);

    // Valid bits for the input register and both lane stages
    logic holdValid;
    logic stage1Valid;
    logic stage2Valid;

    // Low while in reset, keeps inReady down
    logic running;
    logic accept;

    // Only a real beat at stage 2 can be blocked
    assign advance = !(stage2Valid && !collectReady);

    // Register frees up when it moves on or is empty
    assign inReady = running && (advance || !holdValid);
    assign accept = inValid && inReady;
    assign resValid = stage2Valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            holdValid <= 1'b0;
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
        end else begin
            running <= 1'b1;
            holdValid <= accept || (holdValid && !advance);
            if (advance) begin
                stage1Valid <= holdValid;
                stage2Valid <= stage1Valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            laneIn <= inData;
        end
    end

    // Upstream holds its beat until we take it
    assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> $stable(inData));

endmodule

// ==== rtl/sigmoidLane.sv ====
`timescale 1ns/1ps

module sigmoidLane (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  sigmoidPkg::preAct_t laneIn,
    output sigmoidPkg::act_t    result
);

    // Room for x * 10 plus the rounding half
    localparam int PROD_W = sigmoidPkg::DATA_W + 4;
    localparam int HALF = 1 << (sigmoidPkg::FRAC_W - 1);
    localparam int ADDR_W = $clog2(sigmoidPkg::SEG_COUNT);

    logic signed [PROD_W-1:0] scaled;
    logic signed [PROD_W-1:0] rawIdx;
    sigmoidPkg::lookup_s segNext;
    sigmoidPkg::lookup_s seg;
    logic [ADDR_W-1:0] tableAddr;

    // Round half up to the nearest tenth
    assign scaled = PROD_W'(laneIn) * PROD_W'(10) + PROD_W'(HALF);
    assign rawIdx = scaled >>> sigmoidPkg::FRAC_W;

    always_comb begin
        if (rawIdx <= sigmoidPkg::SEG_MIN) begin
            segNext.kind = sigmoidPkg::SEG_LOW;
            segNext.idx = sigmoidPkg::segIdx_t'(sigmoidPkg::SEG_MIN);
        end else if (rawIdx >= sigmoidPkg::SEG_MAX) begin
            segNext.kind = sigmoidPkg::SEG_HIGH;
            segNext.idx = sigmoidPkg::segIdx_t'(sigmoidPkg::SEG_MAX);
        end else begin
            segNext.kind = sigmoidPkg::SEG_MID;
            segNext.idx = sigmoidPkg::segIdx_t'(rawIdx);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            seg <= segNext;
        end
    end

    assign tableAddr = ADDR_W'(seg.idx - sigmoidPkg::SEG_MIN);

    // Saturated ends skip the table
    always_ff @(posedge clk) begin
        if (advance) begin
            case (seg.kind)
                sigmoidPkg::SEG_LOW:  result <= '0;
                sigmoidPkg::SEG_HIGH: result <= sigmoidPkg::act_t'(1 << sigmoidPkg::FRAC_W);
                default:              result <= sigmoidPkg::SIGMOID_TABLE[tableAddr];
            endcase
        end
    end

    // Inner segments read only inner table entries
    assert property (@(posedge clk) disable iff (rst)
        advance && !$isunknown(seg) && (seg.kind == sigmoidPkg::SEG_MID) |=>
            (result > '0) && (result < sigmoidPkg::act_t'(1 << sigmoidPkg::FRAC_W)));

endmodule

// ==== rtl/activationCollect.sv ====
`timescale 1ns/1ps

module activationCollect #(
    parameter int NUM_LANES = 10
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              resValid,
    input  logic                              advance,
    input  sigmoidPkg::act_t [NUM_LANES-1:0] laneRes,
    output logic                              collectReady,
    output logic                              outValid,
    input  logic                              outReady,
    output sigmoidPkg::act_t [NUM_LANES-1:0] outData
);

    sigmoidPkg::bufState_e state;

    // Second entry, filled only while the head is stalled
    sigmoidPkg::act_t [NUM_LANES-1:0] spare;

    logic push;
    logic pop;

    assign push = resValid && advance;
    assign pop = outValid && outReady;
    assign outValid = (state != sigmoidPkg::BUF_EMPTY);
    assign collectReady = (state != sigmoidPkg::BUF_TWO);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sigmoidPkg::BUF_EMPTY;
        end else begin
            case (state)
                sigmoidPkg::BUF_EMPTY: begin
                    if (push) begin
                        state <= sigmoidPkg::BUF_ONE;
                    end
                end
                sigmoidPkg::BUF_ONE: begin
                    if (push && !pop) begin
                        state <= sigmoidPkg::BUF_TWO;
                    end else if (pop && !push) begin
                        state <= sigmoidPkg::BUF_EMPTY;
                    end
                end
                sigmoidPkg::BUF_TWO: begin
                    if (pop && !push) begin
                        state <= sigmoidPkg::BUF_ONE;
                    end
                end
                default: state <= sigmoidPkg::BUF_EMPTY;
            endcase
        end
    end

    // Head register drives outData directly
    always_ff @(posedge clk) begin
        case (state)
            sigmoidPkg::BUF_EMPTY: begin
                if (push) begin
                    outData <= laneRes;
                end
            end
            sigmoidPkg::BUF_ONE: begin
                if (push && pop) begin
                    outData <= laneRes;
                end else if (push) begin
                    spare <= laneRes;
                end
            end
            sigmoidPkg::BUF_TWO: begin
                if (pop) begin
                    outData <= spare;
                    if (push) begin
                        spare <= laneRes;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // Dispatcher must freeze the lanes once both entries are full
    assert property (@(posedge clk) disable iff (rst)
        (state == sigmoidPkg::BUF_TWO) && push |-> pop);

endmodule

// ==== rtl/sigmoidLayer.sv ====
`timescale 1ns/1ps

module sigmoidLayer #(
    parameter int NUM_LANES = 10
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 inValid,
    output logic                                 inReady,
    input  sigmoidPkg::preAct_t [NUM_LANES-1:0] inData,
    output logic                                 outValid,
    input  logic                                 outReady,
    output sigmoidPkg::act_t [NUM_LANES-1:0]    outData
);

    sigmoidPkg::preAct_t [NUM_LANES-1:0] laneIn;
    sigmoidPkg::act_t [NUM_LANES-1:0] laneRes;
    logic advance;
    logic resValid;
    logic collectReady;

    neuronDispatch #(
        .NUM_LANES(NUM_LANES)
    ) dispatch0 (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inData(inData),
        .collectReady(collectReady),
        .laneIn(laneIn),
        .advance(advance),
        .resValid(resValid)
    );

    // One lane per value of the beat
    for (genvar i = 0; i < NUM_LANES; i++) begin : genLane
        sigmoidLane lane (
            .clk(clk),
            .rst(rst),
            .advance(advance),
            .laneIn(laneIn[i]),
            .result(laneRes[i])
        );
    end

    activationCollect #(
        .NUM_LANES(NUM_LANES)
    ) collect0 (
        .clk(clk),
        .rst(rst),
        .resValid(resValid),
        .advance(advance),
        .laneRes(laneRes),
        .collectReady(collectReady),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData)
    );

endmodule

// ==== verification/sigmoidRef.svh ====
`ifndef SIGMOID_REF_SVH
`define SIGMOID_REF_SVH

// Segment at steps of one tenth, round half up, clamped to -60..60
function automatic int segmentIndex(input int x);
    int k;
    k = (x * 10 + 128) >>> 8;
    if (k < -60) begin
        k = -60;
    end
    if (k > 60) begin
        k = 60;
    end
    return k;
endfunction

// Activation in 8.8 fixed point for one pre-activation
function automatic int expectedActivation(input logic signed [15:0] x);
    int xi;
    int k;
    real s;
    xi = x;
    k = segmentIndex(xi);
    if (k <= -60) begin
        return 0;
    end
    if (k >= 60) begin
        return 256;
    end
    s = 256.0 / (1.0 + $exp(-k / 10.0));
    return $rtoi(s + 0.5);
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshiftStep(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

// ==== verification/sigmoidLayerTb.sv ====
`timescale 1ns/1ps

module sigmoidLayerTb;

    `include "sigmoidRef.svh"

    localparam int NUM_LANES = 10;
    localparam int NUM_TESTS = 4;
    localparam int SRC_FIXED = 0;
    localparam int SRC_RANDOM = 1;
    localparam int READY_HIGH = 0;
    localparam int READY_RANDOM = 1;

    typedef sigmoidPkg::preAct_t [NUM_LANES-1:0] beat_t;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    logic inReady;
    beat_t inData;
    logic outValid;
    logic outReady;
    sigmoidPkg::act_t [NUM_LANES-1:0] outData;

    // Stimulus table
    string testName [NUM_TESTS];
    int testSrc [NUM_TESTS];
    int testBeats [NUM_TESTS];
    int testReady [NUM_TESTS];
    int testOffset [NUM_TESTS];
    int testLen [NUM_TESTS];
    int fixedVals [0:21];

    logic [31:0] rngState;
    beat_t expQ [$];
    int acceptCycle [$];
    string curName;
    int cycle = 0;
    int outCount;
    int testErrors;
    int errorCount = 0;
    int beatsChecked = 0;
    int watchNs = 0;
    logic checkLatency = 1'b0;
    logic stallSeen = 1'b0;
    sigmoidPkg::act_t [NUM_LANES-1:0] stallData;

    sigmoidLayer #(
        .NUM_LANES(NUM_LANES)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inData(inData),
        .outValid(outValid),
        .outReady(outReady),
        .outData(outData)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState = xorshiftStep(rngState);
        return rngState;
    endfunction

    task automatic loadTable();
        // Zero, half-step edges, around +-6.0, then the saturation pair
        fixedVals = '{0, 12, 13, -12, -13, 25, 26, -25, -26, 128,
                      1523, 1524, -1523, -1524, -1536, 1536, 1549, -1549,
                      256, -256, -32768, 32767};
        testName = '{"segmentRule", "saturation", "randomStream", "backPressure"};
        testSrc = '{SRC_FIXED, SRC_FIXED, SRC_RANDOM, SRC_RANDOM};
        testBeats = '{4, 3, 200, 300};
        testReady = '{READY_HIGH, READY_HIGH, READY_HIGH, READY_RANDOM};
        testOffset = '{0, 20, 0, 0};
        testLen = '{20, 2, 1, 1};
    endtask

    function automatic beat_t makeBeat(input int t, input int b);
        beat_t beat;
        int pos;
        logic [31:0] r;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (testSrc[t] == SRC_FIXED) begin
                pos = testOffset[t] + (b * NUM_LANES + i) % testLen[t];
                beat[i] = sigmoidPkg::preAct_t'(fixedVals[pos]);
            end else begin
                r = nextRandom();
                beat[i] = r[15:0];
            end
        end
        return beat;
    endfunction

    // Scoreboard, sampled on the edge where transfers happen
    always @(posedge clk) begin : scoreboard
        beat_t exp;
        int want;
        int lat;
        cycle++;
        if (!rst) begin
            if (stallSeen && (!outValid || outData != stallData)) begin
                $display("test %s: outData changed while stalled", curName);
                testErrors++;
            end
            stallSeen = outValid && !outReady;
            stallData = outData;
            if (inValid && inReady) begin
                expQ.push_back(inData);
                acceptCycle.push_back(cycle);
            end
            if (outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("test %s: output beat with nothing pending", curName);
                    testErrors++;
                end else begin
                    exp = expQ.pop_front();
                    lat = cycle - acceptCycle.pop_front();
                    for (int i = 0; i < NUM_LANES; i++) begin
                        want = expectedActivation(exp[i]);
                        if (int'(outData[i]) != want) begin
                            $display("[FAIL] %s lane %0d: expected %0d, actual %0d",
                                     curName, i, want, outData[i]);
                            testErrors++;
                        end
                    end
                    if (checkLatency && lat != 4) begin
                        $display("[FAIL] %s latency: expected 4, actual %0d", curName, lat);
                        testErrors++;
                    end
                    beatsChecked++;
                end
                outCount++;
            end
        end
    end

    task automatic runTest(input int t);
        int issued;
        issued = 0;
        outCount = 0;
        testErrors = 0;
        curName = testName[t];
        checkLatency = (testReady[t] == READY_HIGH);
        while (outCount < testBeats[t]) begin
            @(posedge clk);
            if (!inValid || inReady) begin
                if (issued < testBeats[t]) begin
                    inData <= makeBeat(t, issued);
                    inValid <= 1'b1;
                    issued++;
                end else begin
                    inValid <= 1'b0;
                end
            end
            if (testReady[t] == READY_RANDOM) begin
                outReady <= nextRandom() > 32'h8000_0000;
            end else begin
                outReady <= 1'b1;
            end
        end
        outReady <= 1'b1;
    endtask

    // Watchdog
    initial begin
        wait (watchNs > 0);
        #(watchNs);
        $display("Watchdog: run stopped after %0d ns without finishing", watchNs);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : mainFlow
        int passed;
        int failed;
        int budget;
        rst = 1'b1;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        rngState = 32'h5e42_777c;
        passed = 0;
        failed = 0;
        loadTable();
        // Random ready tests may stall about once per beat
        budget = 16 + 50;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += testBeats[t];
            if (testReady[t] == READY_RANDOM) begin
                budget += testBeats[t];
            end
        end
        watchNs = budget * 8 * 4;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // After reset
        curName = "afterReset";
        testErrors = 0;
        for (int w = 0; w < 4 && !inReady; w++) begin
            @(posedge clk);
            if (outValid) begin
                $display("test afterReset: outValid high after reset");
                testErrors++;
            end
        end
        if (!inReady) begin
            $display("test afterReset: inReady did not rise after reset");
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("test afterReset passed");
            passed++;
        end else begin
            $display("test afterReset failed with %0d errors", testErrors);
            failed++;
        end
        errorCount += testErrors;
        outReady <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
            if (testErrors == 0) begin
                $display("test %s passed, %0d beats", testName[t], testBeats[t]);
                passed++;
            end else begin
                $display("test %s failed with %0d errors", testName[t], testErrors);
                failed++;
            end
            errorCount += testErrors;
        end

        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            $display("%0d accepted beats never came out", expQ.size());
            errorCount++;
        end
        $display("Tests %0d passed, %0d failed, %0d beats checked, %0d errors",
                 passed, failed, beatsChecked, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verification
rtl/sigmoidPkg.sv
rtl/neuronDispatch.sv
rtl/sigmoidLane.sv
rtl/activationCollect.sv
rtl/sigmoidLayer.sv
verification/sigmoidLayerTb.sv
